/* Makefile */
TOP = fetch_tb

all: run

build:
	verilator --binary --timing -f compile.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

/* compile.f */
hdl/fetch_pkg.sv
hdl/rv_isa_pkg.sv
hdl/inst_cache.sv
hdl/branch_predictor.sv
hdl/inst_fetcher.sv
hdl/fetch_top.sv
dv/fetch_tb.sv

/* dv/fetch_tb.sv */
`timescale 1ns/1ps

module fetch_tb;
    import fetch_pkg::*;
    import rv_isa_pkg::*;

    localparam int N_INST  = 600;
    localparam int MAX_LAT = 6;
    localparam int TIMEOUT = 20 * N_INST * MAX_LAT;

    logic  clk_in = 1'b0;
    logic  br_reset = 1'b1;
    logic  rdy_in = 1'b1;
    logic  stall = 1'b0;
    logic  redirect_valid = 1'b0;
    addr_t redirect_pc = '0;
    logic  jalr_valid = 1'b0;
    addr_t jalr_pc = '0;
    logic  mem_valid = 1'b0;
    inst_t mem_data = '0;
    logic  upd_valid = 1'b0;
    addr_t upd_pc = '0;
    logic  upd_taken = 1'b0;
    logic  mem_req;
    addr_t mem_addr;
    logic  dec_valid;
    inst_t dec_inst;
    addr_t dec_pc;
    addr_t dec_next_pc;

    logic [15:0] prog [512];                       // 1 KB program image
    logic [1:0]  bht_m [BHT_ENTRIES] = '{default: 2'd1};
    cache_tag_t  shadow_tag [CACHE_LINES];
    logic [CACHE_LINES-1:0] shadow_valid = '0;
    addr_t exp_pc = '0;
    inst_t exp_inst;
    addr_t exp_next;
    addr_t mem_req_addr = '0;   // address seen when the read started
    logic  jalr_wait = 1'b0;
    logic  rdy_prev = 1'b0;
    logic  stall_prev = 1'b0;
    logic  rdy_next;
    logic  mem_busy = 1'b0;
    int    mem_cnt = 0;
    int    stall_left = 0;
    int    rst_cnt = 0;
    int    cycles = 0;
    int    n_checked = 0;
    logic  timed_out = 1'b0;

    fetch_top DUT (.*);

    initial begin
        forever #4 clk_in = ~clk_in;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp)
            report_failure($sformatf("Mismatch at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
    endtask

    task automatic check_inst(input string name, input inst_t got, input inst_t exp);
        if (got !== exp)
            report_failure($sformatf("Mismatch at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
    endtask

    function automatic inst_t parcel_at(input addr_t a);
        logic [8:0] h;
        h = a[9:1];   // image repeats every 1 KB
        return {prog[h + 9'd1], prog[h]};
    endfunction

    function automatic logic is_jalr_inst(input inst_t i);
        return (i[1:0] == QUAD_FULL) && (i[6:0] == OP_JALR);
    endfunction

    // architectural next pc, branches follow the model counters
    function automatic addr_t next_pc_of(input addr_t pc, input inst_t i);
        logic [20:0] j;
        logic [11:0] cj;
        logic [12:0] b;
        logic [8:0]  cb;
        logic        full;
        logic        c1;
        logic        taken;
        full  = (i[1:0] == QUAD_FULL);
        c1    = (i[1:0] == QUAD_C1);
        j     = {i[31], i[19:12], i[20], i[30:21], 1'b0};
        cj    = {i[12], i[8], i[10:9], i[6], i[7], i[2], i[11], i[5:3], 1'b0};
        b     = {i[31], i[7], i[30:25], i[11:8], 1'b0};
        cb    = {i[12], i[6:5], i[2], i[11:10], i[4:3], 1'b0};
        taken = bht_m[pc[5:1]] >= 2'd2;
        if (full && i[6:0] == OP_JAL)
            return pc + {{11{j[20]}}, j};
        if (c1 && (i[15:13] == C_FUNCT3_J || i[15:13] == C_FUNCT3_JAL))
            return pc + {{20{cj[11]}}, cj};
        if (taken && full && i[6:0] == OP_BRANCH)
            return pc + {{19{b[12]}}, b};
        if (taken && c1 && (i[15:13] == C_FUNCT3_BEQZ || i[15:13] == C_FUNCT3_BNEZ))
            return pc + {{23{cb[8]}}, cb};
        return full ? pc + 32'd4 : pc + 32'd2;
    endfunction

    // mostly addi / c.addi, with jumps and branches mixed in
    task automatic build_program();
        int    h;
        int    k;
        int    off;
        logic [31:0] r;
        logic [20:0] o;
        inst_t w;
        h = 0;
        while (h < 512) begin
            k   = int'($urandom % 100);
            r   = $urandom;
            off = int'($urandom % 512) * 2 - h * 2;   // target inside the program
            o   = off[20:0];
            if (k < 30 || h == 511)   // last halfword only fits a 16-bit op
                w = {16'h0, 3'b000, r[12:2], 2'b01};
            else if (k < 60)
                w = {r[31:20], r[19:15], 3'b000, r[11:7], 7'b0010011};
            else if (k < 68)
                w = {o[20], o[10:1], o[11], o[19:12], 5'd1, OP_JAL};
            else if (k < 76)
                w = {16'h0, r[0] ? C_FUNCT3_JAL : C_FUNCT3_J, o[11], o[4], o[9:8], o[10],
                     o[6], o[7], o[3:1], o[5], 2'b01};
            else if (k < 86)
                w = {o[12], o[10:5], 5'd3, 5'd2, 3'b001, o[4:1], o[11], OP_BRANCH};
            else if (k < 94) begin
                o = 21'(int'(r[5:0]) * 2 - 64);   // short reach
                w = {16'h0, C_FUNCT3_BNEZ, o[8], o[4:3], 3'd2, o[7:6], o[2:1], o[5], 2'b01};
            end else
                w = {12'd0, 5'd1, 3'b000, 5'd0, OP_JALR};
            prog[h] = w[15:0];
            if (w[1:0] == QUAD_FULL) begin
                prog[h + 1] = w[31:16];
                h = h + 2;
            end else begin
                h = h + 1;
            end
        end
    endtask

    always @(posedge clk_in) begin
        if (rst_cnt < 10) begin
            rst_cnt = rst_cnt + 1;
            br_reset <= 1'b1;
        end else begin
            br_reset <= 1'b0;
            if (!br_reset) begin
                cycles = cycles + 1;
                if (cycles > TIMEOUT)
                    timed_out = 1'b1;
                // decoder side, only fresh pulses
                if (dec_valid && rdy_prev) begin
                    if (stall_prev)
                        report_failure("dec_valid came out of a stalled cycle");
                    if (jalr_wait)
                        report_failure("dec_valid appeared before the jalr target was given");
                    exp_inst = parcel_at(exp_pc);
                    exp_next = next_pc_of(exp_pc, exp_inst);
                    check_addr("dec_pc", dec_pc, exp_pc);
                    check_inst("dec_inst", dec_inst, exp_inst);
                    check_addr("dec_next_pc", dec_next_pc, exp_next);
                    if (is_jalr_inst(exp_inst))
                        jalr_wait = 1'b1;
                    else
                        exp_pc = exp_next;
                    n_checked = n_checked + 1;
                end
                // memory side and shadow tags
                if (mem_valid) begin
                    check_addr("mem_addr", mem_addr, mem_req_addr);
                    shadow_valid[mem_addr[4:1]] = 1'b1;
                    shadow_tag[mem_addr[4:1]]   = mem_addr[31:5];
                end else if (mem_req && !mem_busy) begin
                    if (shadow_valid[mem_addr[4:1]] &&
                        shadow_tag[mem_addr[4:1]] == mem_addr[31:5])
                        report_failure("memory read issued for a line already cached");
                    mem_busy     = 1'b1;
                    mem_req_addr = mem_addr;
                    mem_cnt      = 1 + int'($urandom % MAX_LAT);
                end
                if (redirect_valid) begin   // wins over jalr
                    exp_pc    = {redirect_pc[31:1], 1'b0};
                    jalr_wait = 1'b0;
                end else if (jalr_valid) begin
                    exp_pc    = {jalr_pc[31:1], 1'b0};
                    jalr_wait = 1'b0;
                end
                if (upd_valid) begin
                    if (upd_taken && bht_m[upd_pc[5:1]] != 2'd3)
                        bht_m[upd_pc[5:1]] = bht_m[upd_pc[5:1]] + 2'd1;
                    else if (!upd_taken && bht_m[upd_pc[5:1]] != 2'd0)
                        bht_m[upd_pc[5:1]] = bht_m[upd_pc[5:1]] - 2'd1;
                end
                rdy_prev   = rdy_in;
                stall_prev = stall;

                // next stimulus
                rdy_next = !rdy_in || ($urandom % 16) != 0;   // single-cycle dips
                rdy_in         <= rdy_next;
                redirect_valid <= 1'b0;
                jalr_valid     <= 1'b0;
                upd_valid      <= 1'b0;
                mem_valid      <= 1'b0;
                if (stall_left > 0)
                    stall_left = stall_left - 1;
                else if ($urandom % 24 == 0)
                    stall_left = 1 + int'($urandom % 6);
                stall <= (stall_left > 0);
                // counters only train while delivery is stalled
                if (stall_left > 0 && $urandom % 2 == 0) begin
                    upd_valid <= 1'b1;
                    upd_pc    <= $urandom % 1024;
                    upd_taken <= ($urandom % 4) != 0;
                end
                if (rdy_next) begin
                    if ($urandom % 48 == 0) begin
                        redirect_valid <= 1'b1;
                        redirect_pc    <= $urandom % 1024;
                    end else if (jalr_wait && $urandom % 4 == 0) begin
                        jalr_valid <= 1'b1;
                        jalr_pc    <= $urandom % 1024;
                    end
                    if (mem_busy && mem_cnt == 0) begin
                        mem_valid <= 1'b1;
                        mem_data  <= parcel_at(mem_addr);
                        mem_busy = 1'b0;
                    end
                end
                if (mem_busy && mem_cnt > 0)
                    mem_cnt = mem_cnt - 1;
            end
        end
    end

    initial begin
        void'($urandom(62));
        build_program();
        wait (n_checked >= N_INST || timed_out);
        if (timed_out) begin
            $display("Some tests failed");
            $fatal(1, "timeout, the fetch stage stopped delivering instructions");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

/* hdl/branch_predictor.sv */
`timescale 1ns/1ps

module branch_predictor (
    input  logic             clk_in,
    input  logic             br_reset,
    input  fetch_pkg::inst_t pred_inst,
    input  fetch_pkg::addr_t pred_pc,
    output fetch_pkg::addr_t pred_next_pc,
    input  logic             upd_valid,
    input  fetch_pkg::addr_t upd_pc,
    input  logic             upd_taken
);
    import fetch_pkg::*;
    import rv_isa_pkg::*;

    bht_ctr_t   bht [BHT_ENTRIES];
    bht_idx_t   pred_idx;
    bht_idx_t   upd_idx;
    quad_t      quad;
    opcode_t    opcode;
    funct3_t    c_funct3;
    logic       is_full;
    logic       is_branch;
    logic       is_cbranch;
    logic [12:0] b_imm;
    logic [8:0]  cb_imm;
    addr_t      br_offset;
    inst_size_t size;
    logic       predict_taken;

    assign quad     = pred_inst[1:0];
    assign opcode   = pred_inst[6:0];
    assign c_funct3 = pred_inst[15:13];
    assign is_full  = (quad == QUAD_FULL);

    assign is_branch  = is_full && (opcode == OP_BRANCH);
    assign is_cbranch = (quad == QUAD_C1) &&
                        (c_funct3 == C_FUNCT3_BEQZ || c_funct3 == C_FUNCT3_BNEZ);

    // imm[12|10:5] in 31:25, imm[4:1|11] in 11:7
    assign b_imm  = {pred_inst[31], pred_inst[7], pred_inst[30:25], pred_inst[11:8], 1'b0};
    // offset[8|4:3] in 12:10, offset[7:6|2:1|5] in 6:2
    assign cb_imm = {pred_inst[12], pred_inst[6:5], pred_inst[2], pred_inst[11:10],
                     pred_inst[4:3], 1'b0};

    assign br_offset = is_full ? {{19{b_imm[12]}}, b_imm} : {{23{cb_imm[8]}}, cb_imm};
    assign size      = is_full ? INST_SIZE_FULL : INST_SIZE_C;

    assign pred_idx = pred_pc[5:1];
    assign upd_idx  = upd_pc[5:1];

    assign predict_taken = (is_branch || is_cbranch) && (bht[pred_idx] >= BHT_CTR_TAKEN);
    assign pred_next_pc  = predict_taken ? pred_pc + br_offset : pred_pc + addr_t'(size);

    // saturating 2-bit counters, trained by execute
    always_ff @(posedge clk_in) begin
        if (br_reset) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                bht[i] <= BHT_CTR_INIT;
            end
        end else if (upd_valid) begin
            if (upd_taken && bht[upd_idx] != BHT_CTR_MAX) begin
                bht[upd_idx] <= bht[upd_idx] + 2'd1;
            end else if (!upd_taken && bht[upd_idx] != 2'd0) begin
                bht[upd_idx] <= bht[upd_idx] - 2'd1;
            end
        end
    end

endmodule

/* hdl/fetch_pkg.sv */
package fetch_pkg;

    typedef logic [31:0] addr_t;   // byte address
    typedef logic [31:0] inst_t;   // parcel, compressed ones in bits 15:0

    // direct-mapped icache, one 32-bit parcel per line
    localparam int CACHE_LINES = 16;
    localparam int CACHE_IDX_W = 4;

    typedef logic [CACHE_IDX_W-1:0] cache_idx_t;   // addr[4:1]
    typedef logic [26:0]            cache_tag_t;   // addr[31:5]

    // branch history table
    localparam int BHT_ENTRIES = 32;

    typedef logic [4:0] bht_idx_t;   // addr[5:1]
    typedef logic [1:0] bht_ctr_t;

    localparam bht_ctr_t BHT_CTR_INIT  = 2'd1;   // weakly not taken
    localparam bht_ctr_t BHT_CTR_TAKEN = 2'd2;
    localparam bht_ctr_t BHT_CTR_MAX   = 2'd3;

    typedef enum logic [1:0] {
        idle,
        wait_inst,
        wait_jalr
    } fetch_state_t;

endpackage

/* hdl/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
    input  logic             clk_in,
    input  logic             br_reset,
    input  logic             rdy_in,
    input  logic             stall,
    input  logic             redirect_valid,
    input  fetch_pkg::addr_t redirect_pc,
    input  logic             jalr_valid,
    input  fetch_pkg::addr_t jalr_pc,
    output logic             mem_req,
    output fetch_pkg::addr_t mem_addr,
    input  logic             mem_valid,
    input  fetch_pkg::inst_t mem_data,
    input  logic             upd_valid,
    input  fetch_pkg::addr_t upd_pc,
    input  logic             upd_taken,
    output logic             dec_valid,
    output fetch_pkg::inst_t dec_inst,
    output fetch_pkg::addr_t dec_pc,
    output fetch_pkg::addr_t dec_next_pc
);
    import fetch_pkg::*;

    // fetcher <-> cache
    logic  fetch_req;
    addr_t fetch_pc;
    logic  ins_ready;
    inst_t ins_data;
    addr_t ins_pc;

    // fetcher <-> predictor
    inst_t pred_inst;
    addr_t pred_pc;
    addr_t pred_next_pc;

    inst_fetcher u_fetcher (
        .clk_in         (clk_in),
        .br_reset       (br_reset),
        .rdy_in         (rdy_in),
        .stall          (stall),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .jalr_valid     (jalr_valid),
        .jalr_pc        (jalr_pc),
        .fetch_req      (fetch_req),
        .fetch_pc       (fetch_pc),
        .ins_ready      (ins_ready),
        .ins_data       (ins_data),
        .ins_pc         (ins_pc),
        .pred_inst      (pred_inst),
        .pred_pc        (pred_pc),
        .pred_next_pc   (pred_next_pc),
        .dec_valid      (dec_valid),
        .dec_inst       (dec_inst),
        .dec_pc         (dec_pc),
        .dec_next_pc    (dec_next_pc)
    );

    inst_cache u_cache (
        .clk_in    (clk_in),
        .br_reset  (br_reset),
        .rdy_in    (rdy_in),
        .fetch_req (fetch_req),
        .fetch_pc  (fetch_pc),
        .ins_ready (ins_ready),
        .ins_data  (ins_data),
        .ins_pc    (ins_pc),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_valid (mem_valid),
        .mem_data  (mem_data)
    );

    branch_predictor u_predictor (
        .clk_in       (clk_in),
        .br_reset     (br_reset),
        .pred_inst    (pred_inst),
        .pred_pc      (pred_pc),
        .pred_next_pc (pred_next_pc),
        .upd_valid    (upd_valid),
        .upd_pc       (upd_pc),
        .upd_taken    (upd_taken)
    );

endmodule

/* hdl/inst_cache.sv */
`timescale 1ns/1ps

module inst_cache (
    input  logic             clk_in,
    input  logic             br_reset,
    input  logic             rdy_in,
    input  logic             fetch_req,
    input  fetch_pkg::addr_t fetch_pc,
    output logic             ins_ready,
    output fetch_pkg::inst_t ins_data,
    output fetch_pkg::addr_t ins_pc,
    output logic             mem_req,
    output fetch_pkg::addr_t mem_addr,
    input  logic             mem_valid,
    input  fetch_pkg::inst_t mem_data
);
    import fetch_pkg::*;

    logic [CACHE_LINES-1:0] valid_arr;
    cache_tag_t             tag_arr  [CACHE_LINES];
    inst_t                  data_arr [CACHE_LINES];

    addr_t      req_pc;     // last requested pc, may change during a fill
    logic       replay;     // retry lookup of req_pc after a stale fill
    logic       lookup;
    addr_t      look_pc;
    cache_idx_t look_idx;
    cache_idx_t fill_idx;
    logic       hit;
    logic       fill_done;

    // no lookup while the memory port is busy
    assign lookup    = (fetch_req || replay) && !mem_req;
    assign look_pc   = fetch_req ? fetch_pc : req_pc;
    assign look_idx  = look_pc[4:1];
    assign fill_idx  = mem_addr[4:1];
    assign hit       = valid_arr[look_idx] && (tag_arr[look_idx] == look_pc[31:5]);
    assign fill_done = mem_req && mem_valid;

    always_ff @(posedge clk_in) begin
        if (br_reset) begin
            valid_arr <= '0;
            ins_ready <= 1'b0;
            mem_req   <= 1'b0;
            replay    <= 1'b0;
        end else if (rdy_in) begin
            if (fill_done) begin
                mem_req             <= 1'b0;
                valid_arr[fill_idx] <= 1'b1;
                // fetcher moved on while memory was busy
                if (fetch_req || req_pc != mem_addr) begin
                    ins_ready <= 1'b0;
                    replay    <= 1'b1;
                end else begin
                    ins_ready <= 1'b1;
                    replay    <= 1'b0;
                end
            end else if (lookup) begin
                replay    <= 1'b0;
                ins_ready <= hit;
                mem_req   <= !hit;   // miss, start the read
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy_in) begin
            if (fetch_req) begin
                req_pc <= fetch_pc;
            end
            if (fill_done) begin
                tag_arr[fill_idx]  <= mem_addr[31:5];
                data_arr[fill_idx] <= mem_data;
                ins_data           <= mem_data;   // answer straight from the bus
                ins_pc             <= mem_addr;
            end else if (lookup) begin
                ins_data <= data_arr[look_idx];
                ins_pc   <= look_pc;
                if (!hit) begin
                    mem_addr <= look_pc;
                end
            end
        end
    end

endmodule

/* hdl/inst_fetcher.sv */
`timescale 1ns/1ps

module inst_fetcher (
    input  logic             clk_in,
    input  logic             br_reset,
    input  logic             rdy_in,
    input  logic             stall,
    input  logic             redirect_valid,
    input  fetch_pkg::addr_t redirect_pc,
    input  logic             jalr_valid,
    input  fetch_pkg::addr_t jalr_pc,
    output logic             fetch_req,
    output fetch_pkg::addr_t fetch_pc,
    input  logic             ins_ready,
    input  fetch_pkg::inst_t ins_data,
    input  fetch_pkg::addr_t ins_pc,
    output fetch_pkg::inst_t pred_inst,
    output fetch_pkg::addr_t pred_pc,
    input  fetch_pkg::addr_t pred_next_pc,
    output logic             dec_valid,
    output fetch_pkg::inst_t dec_inst,
    output fetch_pkg::addr_t dec_pc,
    output fetch_pkg::addr_t dec_next_pc
);
    import fetch_pkg::*;
    import rv_isa_pkg::*;

    fetch_state_t state;
    addr_t        pc;

    quad_t        quad;
    opcode_t      opcode;
    funct3_t      c_funct3;
    logic         is_jal;
    logic         is_cj;
    logic         is_jalr;
    logic [20:0]  j_imm;
    logic [11:0]  cj_imm;
    addr_t        jump_pc;
    addr_t        next_pc;
    addr_t        jalr_target;

    logic         issue_idle;
    logic         issue_jalr;
    logic         accept;

    assign quad     = ins_data[1:0];
    assign opcode   = ins_data[6:0];
    assign c_funct3 = ins_data[15:13];

    assign is_jal  = (quad == QUAD_FULL) && (opcode == OP_JAL);
    assign is_jalr = (quad == QUAD_FULL) && (opcode == OP_JALR);
    assign is_cj   = (quad == QUAD_C1) &&
                     (c_funct3 == C_FUNCT3_J || c_funct3 == C_FUNCT3_JAL);

    // imm[20|10:1|11|19:12]
    assign j_imm  = {ins_data[31], ins_data[19:12], ins_data[20], ins_data[30:21], 1'b0};
    // offset[11|4|9:8|10|6|7|3:1|5] in 12:2
    assign cj_imm = {ins_data[12], ins_data[8], ins_data[10:9], ins_data[6], ins_data[7],
                     ins_data[2], ins_data[11], ins_data[5:3], 1'b0};

    assign jump_pc = is_jal ? pc + {{11{j_imm[20]}}, j_imm}
                            : pc + {{20{cj_imm[11]}}, cj_imm};

    always_comb begin
        if (is_jal || is_cj) begin
            next_pc = jump_pc;
        end else if (is_jalr) begin
            next_pc = pc + addr_t'(INST_SIZE_FULL);   // fall-through, real target from execute
        end else begin
            next_pc = pred_next_pc;
        end
    end

    assign jalr_target = {jalr_pc[31:1], 1'b0};

    // the predictor sees whatever is being accepted
    assign pred_inst = ins_data;
    assign pred_pc   = pc;

    assign issue_idle = (state == idle) && !stall && !redirect_valid;
    // jalr target is taken even under stall, delivery still waits
    assign issue_jalr = (state == wait_jalr) && jalr_valid && !redirect_valid;
    assign accept     = (state == wait_inst) && !stall && ins_ready && (ins_pc == pc) &&
                        !redirect_valid;

    always_ff @(posedge clk_in) begin
        if (br_reset) begin
            state     <= idle;
            pc        <= '0;
            fetch_req <= 1'b0;
            dec_valid <= 1'b0;
        end else if (rdy_in) begin
            fetch_req <= issue_idle || issue_jalr;   // single-cycle pulse
            dec_valid <= accept;
            if (redirect_valid) begin
                state <= idle;
                pc    <= {redirect_pc[31:1], 1'b0};
            end else if (issue_jalr) begin
                state <= wait_inst;
                pc    <= jalr_target;
            end else if (issue_idle) begin
                state <= wait_inst;
            end else if (accept) begin
                if (is_jalr) begin
                    state <= wait_jalr;   // pc held until execute answers
                end else begin
                    state <= idle;
                    pc    <= next_pc;
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy_in) begin
            if (issue_jalr) begin
                fetch_pc <= jalr_target;
            end else if (issue_idle) begin
                fetch_pc <= pc;
            end
            if (accept) begin
                dec_inst    <= ins_data;
                dec_pc      <= pc;
                dec_next_pc <= next_pc;
            end
        end
    end

endmodule

/* hdl/rv_isa_pkg.sv */
package rv_isa_pkg;

    typedef logic [6:0] opcode_t;
    typedef logic [1:0] quad_t;     // inst[1:0]
    typedef logic [2:0] funct3_t;   // inst[15:13] for compressed
    typedef logic [2:0] inst_size_t;

    // full-width opcodes
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;

    // quadrants, anything but 11 is a 16-bit parcel
    localparam quad_t QUAD_C1   = 2'b01;
    localparam quad_t QUAD_FULL = 2'b11;

    // quadrant 1 control transfers
    localparam funct3_t C_FUNCT3_JAL  = 3'b001;   // rv32 only
    localparam funct3_t C_FUNCT3_J    = 3'b101;
    localparam funct3_t C_FUNCT3_BEQZ = 3'b110;
    localparam funct3_t C_FUNCT3_BNEZ = 3'b111;

    localparam inst_size_t INST_SIZE_FULL = 3'd4;
    localparam inst_size_t INST_SIZE_C    = 3'd2;

endpackage
